// ==== logic/rs_cfg.svh ====
// rs(204,188) code and gf(256) field constants
// shared by the input stage rtl and its testbench
`ifndef RS_CFG_SVH
`define RS_CFG_SVH

// block length in bytes
`define RS_N 204

// parity bytes, one syndrome per parity byte
`define RS_PARITY 16

// field polynomial x^8+x^4+x^3+x^2+1
`define GF_POLY 9'h11D

// block buffer address width
`define BUF_AW 8

// syndromes served by one mac unit
`define SLOTS 8

`endif

// ==== logic/rs_pkg.sv ====
// gf(256) types and table builders
// tables are built by stepping alpha, no stored constants
`default_nettype none

`include "rs_cfg.svh"

package rs_pkg;

   // one field element, or one exponent 0..254
   typedef logic [7:0] gf_t;

   // alpha^e, e taken modulo 255
   function automatic gf_t gf_alog_f(input int e);
      logic [8:0] v;
      int         k;
      v = 9'd1;
      for (k = 0; k < (e % 255); k++)
      begin
         v = v << 1;
         // reduce by the field polynomial on overflow
         if (v[8])
            v = v ^ `GF_POLY;
      end
      return v[7:0];
   endfunction

   // exponent of b; 0 has no log and maps to 0 here
   function automatic gf_t gf_log_f(input gf_t b);
      logic [8:0] v;
      int         e;
      gf_t        res;
      res = '0;
      v   = 9'd1;
      for (e = 0; e < 255; e++)
      begin
         if (v[7:0] == b)
            res = gf_t'(e);
         v = v << 1;
         if (v[8])
            v = v ^ `GF_POLY;
      end
      return res;
   endfunction

endpackage

`default_nettype wire

// ==== logic/gf_log_tables.sv ====
// log and antilog roms for gf(256)
// both reads are registered, one cycle from address to data
`timescale 1ns/1ps
`default_nettype none

`include "rs_cfg.svh"

module gf_log_tables
   import rs_pkg::*;
(
   input  logic clk,
   // log side
   input  gf_t  log_addr,
   output gf_t  log_out,
   output logic log_zero,
   // antilog side
   input  gf_t  alog_addr,
   output gf_t  alog_out
);

   ////////////////////
   // rom contents

   // log_rom[b] = exponent of b, entry 0 unused
   gf_t log_rom  [256];
   // alog_rom[e] = alpha^e, entry 255 wraps to alpha^0
   gf_t alog_rom [256];

   initial
   begin
      for (int a = 0; a < 256; a++)
      begin
         log_rom[a]  = gf_log_f(gf_t'(a));
         alog_rom[a] = gf_alog_f(a);
      end
   end

   ////////////////////
   // registered reads

   always_ff @(posedge clk)
   begin
      log_out  <= log_rom[log_addr];
      // zero byte has no log, flag it beside the lookup
      log_zero <= (log_addr == '0);
   end

   always_ff @(posedge clk)
   begin
      alog_out <= alog_rom[alog_addr];
   end

endmodule

`default_nettype wire

// ==== logic/block_buffer.sv ====
// two-bank ping-pong store for received blocks
// one bank fills while the other is read by later stages
`timescale 1ns/1ps
`default_nettype none

`include "rs_cfg.svh"

module block_buffer
   import rs_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   // write side, one byte per strobe
   input  logic              we,
   input  gf_t               wr_byte,
   // read side
   input  logic [`BUF_AW-1:0] rd_addr,
   input  logic              rd_bank,
   output gf_t               rd_byte,
   // bank holding the last complete block
   output logic              filled_bank
);

   gf_t mem0 [0:`RS_N-1];
   gf_t mem1 [0:`RS_N-1];

   logic [`BUF_AW-1:0] wr_addr;
   logic               wr_bank;

   ////////////////////
   // write address and bank

   // first byte lands at address 203, last at 0
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         wr_addr     <= `BUF_AW'(`RS_N - 1);
         wr_bank     <= 1'b0;
         filled_bank <= 1'b0;
      end
      else if (we)
      begin
         if (wr_addr == '0)
         begin
            // block complete, hand the bank over
            wr_addr     <= `BUF_AW'(`RS_N - 1);
            wr_bank     <= ~wr_bank;
            filled_bank <= wr_bank;
         end
         else
            wr_addr <= wr_addr - 1'b1;
      end
   end

   ////////////////////
   // storage

   always_ff @(posedge clk)
   begin
      if (we)
      begin
         if (wr_bank)
            mem1[wr_addr] <= wr_byte;
         else
            mem0[wr_addr] <= wr_byte;
      end
   end

   // registered read, data one cycle after address
   always_ff @(posedge clk)
   begin
      if (rd_bank)
         rd_byte <= mem1[rd_addr];
      else
         rd_byte <= mem0[rd_addr];
   end

endmodule

`default_nettype wire

// ==== logic/syndrome_mac.sv ====
// log-domain multiply-accumulate for 8 syndromes
// product = alog(log(r) + power), xor'd into the slot accumulator
`timescale 1ns/1ps
`default_nettype none

`include "rs_cfg.svh"

module syndrome_mac
   import rs_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       mac_en,
   input  gf_t        byte_log,
   input  logic       byte_zero,
   input  gf_t        power,
   input  logic [2:0] slot,
   input  logic       block_end,
   output logic       sum_valid,
   output gf_t        sum
);

   logic [8:0] exp_sum;
   gf_t        exp_mod;
   gf_t        prod;

   // inputs delayed to line up with the antilog rom
   logic       en_d;
   logic       end_d;
   logic       zero_d;
   logic [2:0] slot_d;

   gf_t acc      [`SLOTS];
   gf_t acc_next [`SLOTS];
   gf_t bank     [`SLOTS];

   logic       out_busy;
   logic [2:0] out_idx;

   ////////////////////
   // exponent add and antilog

   // both operands below 255, so one subtract is enough
   assign exp_sum = {1'b0, byte_log} + {1'b0, power};
   assign exp_mod = (exp_sum >= 9'd255) ? gf_t'(exp_sum - 9'd255) : exp_sum[7:0];

   // only the antilog half is used here
   gf_log_tables alog_i (
      .clk       (clk),
      .log_addr  ('0),
      .log_out   (),
      .log_zero  (),
      .alog_addr (exp_mod),
      .alog_out  (prod)
   );

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         en_d  <= 1'b0;
         end_d <= 1'b0;
      end
      else
      begin
         en_d  <= mac_en;
         end_d <= block_end;
      end
   end

   always_ff @(posedge clk)
   begin
      zero_d <= byte_zero;
      slot_d <= slot;
   end

   ////////////////////
   // accumulate

   // a zero byte adds nothing
   always_comb
   begin
      acc_next = acc;
      if (en_d && !zero_d)
         acc_next[slot_d] = acc[slot_d] ^ prod;
   end

   ////////////////////
   // hand-over and readout

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         acc       <= '{default: '0};
         bank      <= '{default: '0};
         out_busy  <= 1'b0;
         out_idx   <= '0;
         sum_valid <= 1'b0;
         sum       <= '0;
      end
      else
      begin
         // stream one slot per cycle
         if (out_busy)
         begin
            sum       <= bank[out_idx];
            sum_valid <= 1'b1;
            out_idx   <= out_idx + 1'b1;
            if (out_idx == 3'(`SLOTS - 1))
               out_busy <= 1'b0;
         end
         else
            sum_valid <= 1'b0;

         // block end takes the last product too, next block starts clean
         if (end_d)
         begin
            bank     <= acc_next;
            acc      <= '{default: '0};
            out_busy <= 1'b1;
            out_idx  <= '0;
         end
         else
            acc <= acc_next;
      end
   end

endmodule

`default_nettype wire

// ==== logic/input_syndromes.sv ====
// input handling and syndrome sequencing for rs(204,188)
// feeds the block buffer and two mac units, collects s0..s15
`timescale 1ns/1ps
`default_nettype none

`include "rs_cfg.svh"

module input_syndromes
   import rs_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic ce,
   input  gf_t  in_byte,
   // to the block buffer
   output logic buf_we,
   output gf_t  buf_byte,
   // syndromes of the last block
   output logic s_ready,
   output gf_t  s0, s1, s2, s3,
   output gf_t  s4, s5, s6, s7,
   output gf_t  s8, s9, s10, s11,
   output gf_t  s12, s13, s14, s15
);

   // a - b modulo 255, both in 0..254
   function automatic gf_t sub255(input gf_t a, input gf_t b);
      logic [8:0] d;
      d = {1'b0, a} - {1'b0, b};
      return d[8] ? gf_t'(d[7:0] - 8'd1) : d[7:0];
   endfunction

   logic       ce_d2;
   gf_t        log_out;
   logic       log_zero;
   gf_t        log_q;
   logic       zero_q;

   logic [7:0] byte_cnt;
   logic       last_q;
   gf_t        pow [`RS_PARITY];

   logic       run;
   logic [2:0] slot;

   logic       mac_en;
   logic       mac_end;
   logic [2:0] mac_slot;
   gf_t        mac_log;
   logic       mac_zero;
   gf_t        mac_pow0;
   gf_t        mac_pow1;

   logic       sum_valid0;
   logic       sum_valid1;
   gf_t        sum0;
   gf_t        sum1;
   logic       take;
   logic [2:0] col;
   logic       col_done;
   gf_t        stage [`RS_PARITY];
   gf_t        synd  [`RS_PARITY];

   ////////////////////
   // input capture

   // buffer write one cycle after ce, same register addresses the log rom
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         buf_we <= 1'b0;
         ce_d2  <= 1'b0;
      end
      else
      begin
         buf_we <= ce;
         ce_d2  <= buf_we;
      end
   end

   always_ff @(posedge clk)
   begin
      if (ce)
         buf_byte <= in_byte;
   end

   gf_log_tables log_i (
      .clk       (clk),
      .log_addr  (buf_byte),
      .log_out   (log_out),
      .log_zero  (log_zero),
      .alog_addr ('0),
      .alog_out  ()
   );

   ////////////////////
   // power counters

   // pow[j] = j*(203-i) mod 255 for byte i, held over its 8 slots
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         pow      <= '{default: '0};
         byte_cnt <= '0;
         last_q   <= 1'b0;
      end
      else if (ce_d2)
      begin
         for (int j = 0; j < `RS_PARITY; j++)
         begin
            if (byte_cnt == '0)
               pow[j] <= gf_t'((j * (`RS_N - 1)) % 255);
            else
               pow[j] <= sub255(pow[j], gf_t'(j));
         end
         last_q   <= (byte_cnt == 8'(`RS_N - 1));
         byte_cnt <= (byte_cnt == 8'(`RS_N - 1)) ? '0 : byte_cnt + 8'd1;
      end
   end

   // log held with the powers, the rom moves on with the next byte
   always_ff @(posedge clk)
   begin
      if (ce_d2)
      begin
         log_q  <= log_out;
         zero_q <= log_zero;
      end
   end

   ////////////////////
   // slot sequencing

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         run     <= 1'b0;
         slot    <= '0;
         mac_en  <= 1'b0;
         mac_end <= 1'b0;
      end
      else
      begin
         if (ce_d2)
         begin
            run  <= 1'b1;
            slot <= '0;
         end
         else if (run)
         begin
            if (slot == 3'(`SLOTS - 1))
               run <= 1'b0;
            slot <= slot + 1'b1;
         end
         mac_en  <= run;
         // block closes with slot 7 of byte 203
         mac_end <= run && (slot == 3'(`SLOTS - 1)) && last_q;
      end
   end

   // slot k: unit 0 gets syndrome 2k, unit 1 gets 2k+1
   always_ff @(posedge clk)
   begin
      mac_slot <= slot;
      mac_log  <= log_q;
      mac_zero <= zero_q;
      mac_pow0 <= pow[{slot, 1'b0}];
      mac_pow1 <= pow[{slot, 1'b1}];
   end

   syndrome_mac mac0_i (
      .clk       (clk),
      .reset     (reset),
      .mac_en    (mac_en),
      .byte_log  (mac_log),
      .byte_zero (mac_zero),
      .power     (mac_pow0),
      .slot      (mac_slot),
      .block_end (mac_end),
      .sum_valid (sum_valid0),
      .sum       (sum0)
   );

   syndrome_mac mac1_i (
      .clk       (clk),
      .reset     (reset),
      .mac_en    (mac_en),
      .byte_log  (mac_log),
      .byte_zero (mac_zero),
      .power     (mac_pow1),
      .slot      (mac_slot),
      .block_end (mac_end),
      .sum_valid (sum_valid1),
      .sum       (sum1)
   );

   ////////////////////
   // syndrome collection

   // both units stream in lockstep
   assign take = sum_valid0 && sum_valid1;

   always_ff @(posedge clk)
   begin
      if (take)
      begin
         stage[{col, 1'b0}] <= sum0;
         stage[{col, 1'b1}] <= sum1;
      end
   end

   // outputs change only together with the ready pulse
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         col      <= '0;
         col_done <= 1'b0;
         s_ready  <= 1'b0;
         synd     <= '{default: '0};
      end
      else
      begin
         if (take)
            col <= col + 1'b1;
         col_done <= take && (col == 3'(`SLOTS - 1));
         s_ready  <= col_done;
         if (col_done)
            synd <= stage;
      end
   end

   assign s0  = synd[0];
   assign s1  = synd[1];
   assign s2  = synd[2];
   assign s3  = synd[3];
   assign s4  = synd[4];
   assign s5  = synd[5];
   assign s6  = synd[6];
   assign s7  = synd[7];
   assign s8  = synd[8];
   assign s9  = synd[9];
   assign s10 = synd[10];
   assign s11 = synd[11];
   assign s12 = synd[12];
   assign s13 = synd[13];
   assign s14 = synd[14];
   assign s15 = synd[15];

endmodule

`default_nettype wire

// ==== logic/rs_input_top.sv ====
// rs(204,188) decoder input stage
// block buffer plus syndrome engine
`timescale 1ns/1ps
`default_nettype none

`include "rs_cfg.svh"

module rs_input_top
   import rs_pkg::*;
(
   input  logic               clk,
   input  logic               reset,
   // byte stream, one strobe per byte
   input  logic               ce,
   input  gf_t                in_byte,
   // readback of the completed bank
   input  logic [`BUF_AW-1:0] rd_addr,
   input  logic               rd_bank,
   output gf_t                rd_byte,
   output logic               filled_bank,
   // syndromes
   output logic               s_ready,
   output gf_t                s0, s1, s2, s3,
   output gf_t                s4, s5, s6, s7,
   output gf_t                s8, s9, s10, s11,
   output gf_t                s12, s13, s14, s15
);

   // write path from input capture into the buffer
   logic buf_we;
   gf_t  buf_byte;

   block_buffer buffer_i (
      .clk         (clk),
      .reset       (reset),
      .we          (buf_we),
      .wr_byte     (buf_byte),
      .rd_addr     (rd_addr),
      .rd_bank     (rd_bank),
      .rd_byte     (rd_byte),
      .filled_bank (filled_bank)
   );

   input_syndromes synd_i (
      .clk      (clk),
      .reset    (reset),
      .ce       (ce),
      .in_byte  (in_byte),
      .buf_we   (buf_we),
      .buf_byte (buf_byte),
      .s_ready  (s_ready),
      .s0, .s1, .s2, .s3,
      .s4, .s5, .s6, .s7,
      .s8, .s9, .s10, .s11,
      .s12, .s13, .s14, .s15
   );

endmodule

`default_nettype wire

// ==== tb/rs_input_asserts.sv ====
// protocol checks on the syndrome engine
// strobe spacing and ready pulse width
`timescale 1ns/1ps
`default_nettype none

module rs_input_asserts
(
   input logic clk,
   input logic reset,
   input logic ce,
   input logic s_ready
);

   // cycles since the last strobe, saturates at 7
   logic [2:0] gap;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         gap <= 3'd7;
      else if (ce)
         gap <= '0;
      else if (gap != 3'd7)
         gap <= gap + 3'd1;
   end

   ////////////////////
   // properties

   // each byte needs all 8 mac slots before the next one
   ce_spacing: assert property (@(posedge clk) disable iff (reset) ce |-> gap == 3'd7)
      else $error("ce strobes closer than 8 cycles");

   ready_one_cycle: assert property (@(posedge clk) disable iff (reset) s_ready |=> !s_ready)
      else $error("s_ready high for more than one cycle");

endmodule

bind input_syndromes rs_input_asserts asserts_i (
   .clk     (clk),
   .reset   (reset),
   .ce      (ce),
   .s_ready (s_ready)
);

`default_nettype wire

// ==== tb/tb_rs_input.sv ====
// testbench for the rs(204,188) input stage
// directed blocks checked against a shift-and-add gf(256) model
`timescale 1ns/1ps
`default_nettype none

`include "rs_cfg.svh"

module tb_rs_input
   import rs_pkg::*;
();

   // 6 blocks, each with its strobes, readback and ready latency
   localparam int MAX_CYCLES = 6 * (`RS_N * 8 + `RS_N + 64) + 100;

   logic               clk;
   logic               reset;
   logic               ce;
   gf_t                in_byte;
   logic [`BUF_AW-1:0] rd_addr;
   logic               rd_bank;
   gf_t                rd_byte;
   logic               filled_bank;
   logic               s_ready;
   gf_t [`RS_PARITY-1:0] synd_out;

   // two block slots with their expected syndromes
   gf_t    blk      [2][`RS_N];
   gf_t    synd_exp [2][`RS_PARITY];
   gf_t    gen      [`RS_PARITY + 1];
   integer seed;
   int     cycles;
   logic   next_bank;

   rs_input_top dut_i (
      .clk         (clk),
      .reset       (reset),
      .ce          (ce),
      .in_byte     (in_byte),
      .rd_addr     (rd_addr),
      .rd_bank     (rd_bank),
      .rd_byte     (rd_byte),
      .filled_bank (filled_bank),
      .s_ready     (s_ready),
      .s0 (synd_out[0]), .s1 (synd_out[1]), .s2 (synd_out[2]), .s3 (synd_out[3]),
      .s4 (synd_out[4]), .s5 (synd_out[5]), .s6 (synd_out[6]), .s7 (synd_out[7]),
      .s8 (synd_out[8]), .s9 (synd_out[9]), .s10 (synd_out[10]), .s11 (synd_out[11]),
      .s12 (synd_out[12]), .s13 (synd_out[13]), .s14 (synd_out[14]), .s15 (synd_out[15])
   );

   always #50 clk = ~clk;

   ////////////////////
   // run limit

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles > MAX_CYCLES)
         abort_run($sformatf("timeout, run went past %0d clock cycles", MAX_CYCLES));
   end

   ////////////////////
   // gf(256) model

   // shift-and-add multiply, reduce on overflow
   function automatic gf_t gf_mul(input gf_t a, input gf_t b);
      logic [8:0] x;
      gf_t        r;
      int         k;
      r = '0;
      x = {1'b0, a};
      for (k = 0; k < 8; k++)
      begin
         if (b[k])
            r = r ^ x[7:0];
         x = x << 1;
         if (x[8])
            x = x ^ `GF_POLY;
      end
      return r;
   endfunction

   // g(x) = product of (x + alpha^k), k = 0..15, gen[i] is coefficient of x^i
   task automatic build_generator();
      gf_t root;
      int  i;
      int  k;
      gen    = '{default: '0};
      gen[0] = 8'd1;
      for (k = 0; k < `RS_PARITY; k++)
      begin
         root = gf_alog_f(k);
         for (i = `RS_PARITY; i > 0; i--)
            gen[i] = gen[i-1] ^ gf_mul(gen[i], root);
         gen[0] = gf_mul(gen[0], root);
      end
   endtask

   // systematic encoding, parity fills bytes 188..203
   task automatic encode_block(input int b);
      gf_t p [`RS_PARITY];
      gf_t fb;
      int  i;
      int  k;
      p = '{default: '0};
      for (i = 0; i < `RS_N - `RS_PARITY; i++)
      begin
         fb = blk[b][i] ^ p[`RS_PARITY-1];
         for (k = `RS_PARITY - 1; k > 0; k--)
            p[k] = p[k-1] ^ gf_mul(fb, gen[k]);
         p[0] = gf_mul(fb, gen[0]);
      end
      for (k = 0; k < `RS_PARITY; k++)
         blk[b][`RS_N - `RS_PARITY + k] = p[`RS_PARITY - 1 - k];
   endtask

   // s_j = sum of r_i * alpha^(j*(203-i))
   task automatic model_syndromes(input int b);
      gf_t s;
      int  i;
      int  j;
      for (j = 0; j < `RS_PARITY; j++)
      begin
         s = '0;
         for (i = 0; i < `RS_N; i++)
            s = s ^ gf_mul(blk[b][i], gf_alog_f(j * (`RS_N - 1 - i)));
         synd_exp[b][j] = s;
      end
   endtask

   task automatic fill_random(input int b);
      int i;
      for (i = 0; i < `RS_N; i++)
         blk[b][i] = gf_t'($random(seed));
   endtask

   ////////////////////
   // checking

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_val(input logic [31:0] got, input logic [31:0] exp,
                            input string what);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED at %0t: %s, got %0h expected %0h",
                             $time, what, got, exp));
   endtask

   ////////////////////
   // driving

   // all driving tasks start and end 1 ns after a rising edge
   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   // one strobe every 8 cycles
   task automatic send_block(input int b);
      int i;
      for (i = 0; i < `RS_N; i++)
      begin
         ce      = 1'b1;
         in_byte = blk[b][i];
         wait_cycles(1);
         ce      = 1'b0;
         wait_cycles(7);
      end
   endtask

   task automatic wait_ready(input int limit);
      int n;
      n = 0;
      do
      begin
         wait_cycles(1);
         n++;
         if (n > limit)
            abort_run($sformatf("s_ready did not arrive within %0d cycles", limit));
      end
      while (!s_ready);
   endtask

   task automatic check_syndromes(input int b, input logic bank);
      int j;
      for (j = 0; j < `RS_PARITY; j++)
         check_val(synd_out[j], synd_exp[b][j], $sformatf("s%0d of block slot %0d", j, b));
      check_val(filled_bank, bank, "filled_bank at s_ready");
   endtask

   // byte i of the block sits at address 203-i
   task automatic check_readback(input int b, input logic bank);
      int a;
      rd_bank = bank;
      for (a = 0; a < `RS_N; a++)
      begin
         rd_addr = `BUF_AW'(a);
         wait_cycles(1);
         check_val(rd_byte, blk[b][`RS_N - 1 - a], $sformatf("bank %0d address %0d", bank, a));
      end
   endtask

   task automatic run_block(input int b);
      send_block(b);
      wait_ready(64);
      check_syndromes(b, next_bank);
      check_readback(b, next_bank);
      next_bank = ~next_bank;
   endtask

   ////////////////////
   // directed tests

   task automatic after_reset();
      int j;
      check_val(s_ready, 1'b0, "s_ready after reset");
      check_val(filled_bank, 1'b0, "filled_bank after reset");
      for (j = 0; j < `RS_PARITY; j++)
         check_val(synd_out[j], 8'h00, $sformatf("s%0d after reset", j));
   endtask

   task automatic zero_and_codeword();
      blk[0]      = '{default: '0};
      synd_exp[0] = '{default: '0};
      run_block(0);
      // random message, parity from the generator polynomial
      fill_random(0);
      encode_block(0);
      run_block(0);
   endtask

   task automatic random_block();
      fill_random(0);
      model_syndromes(0);
      run_block(0);
   endtask

   // error e at p adds e * alpha^(j*(203-p)) to every syndrome
   task automatic single_error();
      gf_t e;
      int  p;
      int  j;
      e = gf_t'($random(seed));
      if (e == '0)
         e = 8'h01;
      p = $unsigned($random(seed)) % `RS_N;
      blk[1] = blk[0];
      blk[1][p] = blk[0][p] ^ e;
      for (j = 0; j < `RS_PARITY; j++)
         synd_exp[1][j] = synd_exp[0][j] ^ gf_mul(e, gf_alog_f(j * (`RS_N - 1 - p)));
      run_block(1);
   endtask

   // second block starts right after the first, first readout overlaps it
   task automatic back_to_back();
      logic bank_a;
      bank_a = next_bank;
      fill_random(0);
      fill_random(1);
      model_syndromes(0);
      model_syndromes(1);
      fork
         begin
            send_block(0);
            send_block(1);
         end
         begin
            wait_ready(`RS_N * 8 + 64);
            check_syndromes(0, bank_a);
            wait_ready(`RS_N * 8 + 64);
            check_syndromes(1, ~bank_a);
         end
      join
      check_readback(0, bank_a);
      check_readback(1, ~bank_a);
      next_bank = bank_a;
   endtask

   initial
   begin
      clk       = 1'b0;
      reset     = 1'b1;
      ce        = 1'b0;
      in_byte   = '0;
      rd_addr   = '0;
      rd_bank   = 1'b0;
      cycles    = 0;
      seed      = 32'h8a77663f;
      next_bank = 1'b0;
      build_generator();

      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      wait_cycles(2);

      after_reset();
      zero_and_codeword();
      random_block();
      single_error();
      back_to_back();

      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+logic
logic/rs_pkg.sv
logic/gf_log_tables.sv
logic/block_buffer.sv
logic/syndrome_mac.sv
logic/input_syndromes.sv
logic/rs_input_top.sv
tb/rs_input_asserts.sv
tb/tb_rs_input.sv

// ==== Makefile ====
# Verilator build and run of the rs(204,188) input stage testbench
TOP = tb_rs_input

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean
